// File: flist.f
+incdir+src
src/lc3b_types_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_ctrl_if.sv
src/cache_way.sv
src/cache_l1_datapath.sv
src/cache_l1_control.sv
src/cache_l1.sv
verification/cache_mem_model.sv
verification/cache_l1_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_l1_tb
RTL_TOP   ?= cache_l1
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "$(RTL_TOP) simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "$(RTL_TOP) simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/cache_l1_tb.sv
`include "lc3b_cache_macros.svh"

module cache_l1_tb
    import lc3b_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD    = 20;
    localparam int SAMPLE_DELAY   = 10;
    localparam int RESET_CYCLES   = 4;
    localparam int CYCLES_PER_REQ = 30;

    typedef struct {
        logic           we;
        lc3b_line_addr  adr;
        lc3b_cache_sel  sel;
        lc3b_cache_word data;
        int             exp_reads;
        int             exp_writes;
        lc3b_line_addr  wb_adr;
    } stim_entry_t;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           cpu_cyc;
    logic           cpu_stb;
    logic           cpu_we;
    lc3b_line_addr  cpu_adr;
    lc3b_cache_sel  cpu_sel;
    lc3b_cache_word cpu_dat_m;
    lc3b_cache_word cpu_dat_s;
    logic           cpu_ack;
    logic           mem_cyc;
    logic           mem_stb;
    logic           mem_we;
    lc3b_line_addr  mem_adr;
    lc3b_cache_sel  mem_sel;
    lc3b_cache_word mem_dat_m;
    lc3b_cache_word mem_dat_s;
    logic           mem_ack;
    int             read_count;
    int             write_count;

    stim_entry_t    stim_q[$];
    lc3b_cache_word shadow [lc3b_line_addr];
    lc3b_line_addr  wb_adr_q[$];
    int             wb_reads_q[$];
    int             mismatch_errors = 0;
    int             other_errors = 0;
    int             cycle_count = 0;
    int             timeout_limit = 0;

    always #HALF_PERIOD clk = ~clk;

    cache_l1 cache_l1_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_sel   (cpu_sel),
        .cpu_dat_m (cpu_dat_m),
        .cpu_dat_s (cpu_dat_s),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_dat_m (mem_dat_m),
        .mem_dat_s (mem_dat_s),
        .mem_ack   (mem_ack)
    );

    cache_mem_model cache_mem_model_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cyc         (mem_cyc),
        .stb         (mem_stb),
        .we          (mem_we),
        .adr         (mem_adr),
        .sel         (mem_sel),
        .dat_m       (mem_dat_m),
        .dat_s       (mem_dat_s),
        .ack         (mem_ack),
        .read_count  (read_count),
        .write_count (write_count)
    );

    // contents of a line before anything was written to it
    function automatic lc3b_cache_word initial_line(lc3b_line_addr a);
        lc3b_cache_word line;
        for (int i = 0; i < 8; i++) begin
            line[16*i +: 16] = {4'(i), a} ^ 16'hc3a5;
        end
        return line;
    endfunction

    function automatic lc3b_cache_word expected_line(lc3b_line_addr a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return initial_line(a);
    endfunction

    task automatic shadow_write(lc3b_line_addr a, lc3b_cache_sel s, lc3b_cache_word d);
        lc3b_cache_word line;
        line = expected_line(a);
        for (int i = 0; i < `CACHE_SEL_BITS; i++) begin
            if (s[i]) begin
                line[8*i +: 8] = d[8*i +: 8];
            end
        end
        shadow[a] = line;
    endtask

    task automatic add_stim(logic we, lc3b_line_addr adr, lc3b_cache_sel sel,
                            lc3b_cache_word data, int reads, int writes,
                            lc3b_line_addr wb_adr);
        stim_entry_t e;
        e.we         = we;
        e.adr        = adr;
        e.sel        = sel;
        e.data       = data;
        e.exp_reads  = reads;
        e.exp_writes = writes;
        e.wb_adr     = wb_adr;
        stim_q.push_back(e);
    endtask

    task automatic check_word(string name, lc3b_cache_word exp, lc3b_cache_word act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(string name, lc3b_line_addr exp, lc3b_line_addr act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_sel(string name, lc3b_cache_sel exp, lc3b_cache_sel act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // record every completed write-back with the read count at that moment
    always @(negedge clk) begin
        if (rst_n && mem_stb) begin
            check_sel("mem_sel", '1, mem_sel);
        end
        if (rst_n && mem_stb && mem_we && mem_ack) begin
            wb_adr_q.push_back(mem_adr);
            wb_reads_q.push_back(read_count);
            // victim line leaves with every byte the CPU wrote into it
            check_word("mem_dat_m", expected_line(mem_adr), mem_dat_m);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout after %0d cycles, a request never completed", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // one request, held until cpu_ack, then memory traffic is compared
    task automatic apply_entry(stim_entry_t e);
        int reads_before;
        int writes_before;
        reads_before  = read_count;
        writes_before = write_count;
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = e.we;
        cpu_adr   = e.adr;
        cpu_sel   = e.sel;
        cpu_dat_m = e.data;
        #SAMPLE_DELAY;
        while (cpu_ack !== 1'b1) begin
            @(negedge clk);
            #SAMPLE_DELAY;
        end
        if (e.we) begin
            shadow_write(e.adr, e.sel, e.data);
        end else begin
            check_word("cpu_dat_s", expected_line(e.adr), cpu_dat_s);
        end
        @(negedge clk);
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        check_count("memory reads", e.exp_reads, read_count - reads_before);
        check_count("memory writes", e.exp_writes, write_count - writes_before);
        if (e.exp_writes > 0) begin
            if (wb_adr_q.size() == 0) begin
                other_errors++;
                $display("Error at %0t: no write-back was recorded on the memory bus", $time);
            end else begin
                check_addr("mem_adr", e.wb_adr, wb_adr_q.pop_front());
                // the victim must leave before the fill read starts
                check_count("reads before write-back", reads_before, wb_reads_q.pop_front());
            end
        end
        @(negedge clk);
    endtask

    initial begin
        // set 3: X, Y, Z; set 5: A, B, C, W
        add_stim(1'b0, 12'h123, 16'h0000, 128'h0, 1, 0, 12'h000);
        add_stim(1'b0, 12'h123, 16'h0000, 128'h0, 0, 0, 12'h000);
        add_stim(1'b1, 12'h123, 16'h00f0,
                 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 0, 0, 12'h000);
        add_stim(1'b0, 12'h123, 16'h0000, 128'h0, 0, 0, 12'h000);
        add_stim(1'b0, 12'h015, 16'h0000, 128'h0, 1, 0, 12'h000);
        add_stim(1'b0, 12'h025, 16'h0000, 128'h0, 1, 0, 12'h000);
        add_stim(1'b0, 12'h015, 16'h0000, 128'h0, 0, 0, 12'h000);
        add_stim(1'b0, 12'h035, 16'h0000, 128'h0, 1, 0, 12'h000);
        add_stim(1'b0, 12'h015, 16'h0000, 128'h0, 0, 0, 12'h000);
        add_stim(1'b0, 12'h025, 16'h0000, 128'h0, 1, 0, 12'h000);
        add_stim(1'b0, 12'h133, 16'h0000, 128'h0, 1, 0, 12'h000);
        // X is dirty and the LRU victim here
        add_stim(1'b0, 12'h143, 16'h0000, 128'h0, 1, 1, 12'h123);
        add_stim(1'b0, 12'h123, 16'h0000, 128'h0, 1, 0, 12'h000);
        // write miss allocates the line first
        add_stim(1'b1, 12'h0f5, 16'hf00f,
                 128'hdead_beef_0bad_f00d_1357_9bdf_2468_ace0, 1, 0, 12'h000);
        add_stim(1'b0, 12'h0f5, 16'h0000, 128'h0, 0, 0, 12'h000);
        add_stim(1'b0, 12'h015, 16'h0000, 128'h0, 1, 0, 12'h000);
        add_stim(1'b0, 12'h035, 16'h0000, 128'h0, 1, 1, 12'h0f5);
        add_stim(1'b0, 12'h0f5, 16'h0000, 128'h0, 1, 0, 12'h000);
        timeout_limit = stim_q.size() * CYCLES_PER_REQ + RESET_CYCLES;

        rst_n     = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_sel   = '0;
        cpu_dat_m = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_bit("cpu_ack", 1'b0, cpu_ack);
        check_bit("mem_cyc", 1'b0, mem_cyc);
        check_bit("mem_stb", 1'b0, mem_stb);
        @(negedge clk);

        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
        end

        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : cache_l1_tb

// File: verification/cache_mem_model.sv
`include "lc3b_cache_macros.svh"

module cache_mem_model
    import lc3b_types_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  lc3b_line_addr  adr,
    input  lc3b_cache_sel  sel,
    input  lc3b_cache_word dat_m,
    output lc3b_cache_word dat_s,
    output logic           ack,
    output int             read_count,
    output int             write_count
);
    timeunit 1ns;
    timeprecision 100ps;

    lc3b_cache_word mem [2**`CACHE_ADR_BITS];
    // lines never written still read back their initial pattern
    logic [2**`CACHE_ADR_BITS-1:0] written;
    logic [1:0]     wait_left;
    logic           accept;
    lc3b_cache_word stored_line;
    lc3b_cache_word merged_line;

    initial begin
        void'($urandom(66021));
    end

    // every halfword mixes its position with the full line address
    function automatic lc3b_cache_word pattern_line(lc3b_line_addr a);
        lc3b_cache_word line;
        for (int i = 0; i < 8; i++) begin
            line[16*i +: 16] = {4'(i), a} ^ 16'hc3a5;
        end
        return line;
    endfunction

    assign accept      = cyc && stb && !ack && (wait_left == 2'd0);
    assign stored_line = written[adr] ? mem[adr] : pattern_line(adr);

    always_comb begin
        merged_line = stored_line;
        for (int i = 0; i < `CACHE_SEL_BITS; i++) begin
            if (sel[i]) begin
                merged_line[8*i +: 8] = dat_m[8*i +: 8];
            end
        end
    end

    always @(posedge clk) begin
        if (accept && we) begin
            mem[adr] <= merged_line;
        end
    end

    // wait states count down while the request is held, then one ack cycle
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            dat_s       <= '0;
            written     <= '0;
            wait_left   <= 2'($urandom_range(3, 0));
            read_count  <= 0;
            write_count <= 0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (wait_left != 2'd0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    ack       <= 1'b1;
                    wait_left <= 2'($urandom_range(3, 0));
                    if (we) begin
                        written[adr] <= 1'b1;
                        write_count  <= write_count + 1;
                    end else begin
                        dat_s      <= stored_line;
                        read_count <= read_count + 1;
                    end
                end
            end
        end
    end

endmodule : cache_mem_model

// File: src/cache_l1.sv
module cache_l1
    import lc3b_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    // CPU-side Wishbone slave
    input  logic            cpu_cyc,
    input  logic            cpu_stb,
    input  logic            cpu_we,
    input  lc3b_line_addr   cpu_adr,
    input  lc3b_cache_sel   cpu_sel,
    input  lc3b_cache_word  cpu_dat_m,
    output lc3b_cache_word  cpu_dat_s,
    output logic            cpu_ack,

    // memory-side Wishbone master
    output logic            mem_cyc,
    output logic            mem_stb,
    output logic            mem_we,
    output lc3b_line_addr   mem_adr,
    output lc3b_cache_sel   mem_sel,
    output lc3b_cache_word  mem_dat_m,
    input  lc3b_cache_word  mem_dat_s,
    input  logic            mem_ack
);

    cache_ctrl_if ctrl_if ();

    cache_l1_control cache_l1_control_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl_if.ctrl),
        .cpu_cyc (cpu_cyc),
        .cpu_stb (cpu_stb),
        .cpu_we  (cpu_we),
        .cpu_ack (cpu_ack),
        .mem_cyc (mem_cyc),
        .mem_stb (mem_stb),
        .mem_we  (mem_we),
        .mem_ack (mem_ack)
    );

    // request fields go straight to the datapath
    cache_l1_datapath cache_l1_datapath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl_if.dp),
        .cpu_adr   (cpu_adr),
        .cpu_sel   (cpu_sel),
        .cpu_dat_m (cpu_dat_m),
        .mem_dat_s (mem_dat_s),
        .cpu_dat_s (cpu_dat_s),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_dat_m (mem_dat_m)
    );

endmodule : cache_l1

// File: src/cache_l1_control.sv
module cache_l1_control
    import cache_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    cache_ctrl_if.ctrl  ctrl,

    // CPU-side Wishbone handshake
    input  logic        cpu_cyc,
    input  logic        cpu_stb,
    input  logic        cpu_we,
    output logic        cpu_ack,

    // memory-side Wishbone handshake
    output logic        mem_cyc,
    output logic        mem_stb,
    output logic        mem_we,
    input  logic        mem_ack
);

    cache_state_e state;
    cache_state_e state_next;

    logic req;
    logic hit;

    assign req = cpu_cyc && cpu_stb;
    assign hit = ctrl.hit_0 || ctrl.hit_1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next           = state;
        cpu_ack              = 1'b0;
        mem_cyc              = 1'b0;
        mem_stb              = 1'b0;
        mem_we               = 1'b0;
        // outside a hit the victim way is the one in play
        ctrl.way_sel         = ctrl.lru;
        ctrl.data_source_sel = 1'b0;
        ctrl.tag_bypass_sel  = 1'b0;
        ctrl.load            = 1'b0;
        ctrl.load_lru        = 1'b0;

        case (state)
            IDLE: begin
                if (req) begin
                    if (hit) begin
                        ctrl.way_sel  = ctrl.hit_1 ? WAY_1 : WAY_0;
                        // ack in the same cycle, writes merge into the hit way
                        cpu_ack       = 1'b1;
                        ctrl.load     = cpu_we;
                        ctrl.load_lru = 1'b1;
                    end else if (ctrl.dirty) begin
                        state_next = WRITEBACK;
                    end else begin
                        state_next = FILL;
                    end
                end
            end

            WRITEBACK: begin
                // victim line to its own address, held through wait states
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                mem_we  = 1'b1;
                if (mem_ack) begin
                    state_next = FILL;
                end
            end

            FILL: begin
                mem_cyc              = 1'b1;
                mem_stb              = 1'b1;
                ctrl.tag_bypass_sel  = 1'b1;
                ctrl.data_source_sel = 1'b1;
                if (mem_ack) begin
                    // request hits on return to IDLE
                    ctrl.load  = 1'b1;
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    a_stb_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_stb |-> mem_cyc
    );

    // a CPU ack only ever ends a request while memory is idle
    a_ack_not_during_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cpu_ack && mem_stb)
    );

endmodule : cache_l1_control

// File: src/cache_l1_datapath.sv
`include "lc3b_cache_macros.svh"

module cache_l1_datapath
    import lc3b_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    cache_ctrl_if.dp        ctrl,
    input  lc3b_line_addr   cpu_adr,
    input  lc3b_cache_sel   cpu_sel,
    input  lc3b_cache_word  cpu_dat_m,
    input  lc3b_cache_word  mem_dat_s,
    output lc3b_cache_word  cpu_dat_s,
    output lc3b_line_addr   mem_adr,
    output lc3b_cache_sel   mem_sel,
    output lc3b_cache_word  mem_dat_m
);

    lc3b_cache_tag   tag_in;
    lc3b_cache_index index;
    lc3b_cache_word  data_in;
    lc3b_cache_sel   byte_sel;

    logic            load_0;
    logic            load_1;
    lc3b_cache_word  data_0;
    lc3b_cache_word  data_1;
    lc3b_cache_tag   tag_0;
    lc3b_cache_tag   tag_1;
    logic            dirty_0;
    logic            dirty_1;

    lc3b_cache_word  data_out;
    lc3b_cache_tag   tag_out;
    lc3b_cache_tag   adr_tag;

    logic [`CACHE_SETS-1:0] lru_arr;

    // split the request line address
    assign tag_in = cpu_adr[`CACHE_ADR_BITS-1:`CACHE_INDEX_BITS];
    assign index  = cpu_adr[`CACHE_INDEX_BITS-1:0];

    // memory transfers always move the whole line
    assign mem_sel = '1;

    // write data and mask by source
    assign data_in  = ctrl.data_source_sel ? mem_dat_s : cpu_dat_m;
    assign byte_sel = ctrl.data_source_sel ? mem_sel : cpu_sel;

    // only the selected way sees the load strobe
    assign load_0 = ctrl.load && (ctrl.way_sel == WAY_0);
    assign load_1 = ctrl.load && (ctrl.way_sel == WAY_1);

    cache_way cache_way_0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load_0),
        .load_type (ctrl.data_source_sel),
        .byte_sel  (byte_sel),
        .tag_in    (tag_in),
        .index     (index),
        .data_in   (data_in),
        .tag_out   (tag_0),
        .data_out  (data_0),
        .dirty_out (dirty_0),
        .hit_out   (ctrl.hit_0)
    );

    cache_way cache_way_1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load_1),
        .load_type (ctrl.data_source_sel),
        .byte_sel  (byte_sel),
        .tag_in    (tag_in),
        .index     (index),
        .data_in   (data_in),
        .tag_out   (tag_1),
        .data_out  (data_1),
        .dirty_out (dirty_1),
        .hit_out   (ctrl.hit_1)
    );

    // line and tag of the selected way
    assign data_out = (ctrl.way_sel == WAY_1) ? data_1 : data_0;
    assign tag_out  = (ctrl.way_sel == WAY_1) ? tag_1 : tag_0;

    // same line goes back to the CPU on a hit and to memory on a write-back
    assign cpu_dat_s = data_out;
    assign mem_dat_m = data_out;

    // victim tag for write-back, request tag for the fill
    assign adr_tag = ctrl.tag_bypass_sel ? tag_in : tag_out;
    assign mem_adr = {adr_tag, index};

    // LRU bit names the way to evict next
    assign ctrl.lru   = way_sel_e'(lru_arr[index]);
    assign ctrl.dirty = (ctrl.lru == WAY_1) ? dirty_1 : dirty_0;

    // after an access the other way becomes least recently used
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_arr <= '0;
        end else if (ctrl.load_lru) begin
            lru_arr[index] <= (ctrl.way_sel == WAY_0);
        end
    end

endmodule : cache_l1_datapath

// File: src/cache_way.sv
`include "lc3b_cache_macros.svh"

module cache_way
    import lc3b_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    // 0 for a CPU write, 1 for a line fill from memory
    input  logic            load_type,
    input  lc3b_cache_sel   byte_sel,
    input  lc3b_cache_tag   tag_in,
    input  lc3b_cache_index index,
    input  lc3b_cache_word  data_in,
    output lc3b_cache_tag   tag_out,
    output lc3b_cache_word  data_out,
    output logic            dirty_out,
    output logic            hit_out
);

    lc3b_cache_word data_arr [`CACHE_SETS];
    lc3b_cache_tag  tag_arr [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_arr;
    logic [`CACHE_SETS-1:0] dirty_arr;

    lc3b_cache_word merged;

    // stored line with the enabled bytes replaced
    // a fill arrives with every byte enabled
    always_comb begin
        merged = data_arr[index];
        for (int i = 0; i < `CACHE_SEL_BITS; i++) begin
            if (byte_sel[i]) begin
                merged[8*i +: 8] = data_in[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_arr[index] <= merged;
            // a CPU write only loads on a hit, so the tag is unchanged there
            tag_arr[index]  <= tag_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (load) begin
            if (load_type) begin
                valid_arr[index] <= 1'b1;
                dirty_arr[index] <= 1'b0;
            end else begin
                dirty_arr[index] <= 1'b1;
            end
        end
    end

    assign data_out  = data_arr[index];
    assign tag_out   = tag_arr[index];
    assign dirty_out = dirty_arr[index];
    assign hit_out   = valid_arr[index] && (tag_arr[index] == tag_in);

    // the set index comes straight from the CPU address at the top level
    a_load_index_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |-> !$isunknown(index)
    );

endmodule : cache_way

// File: src/cache_ctrl_if.sv
interface cache_ctrl_if
    import cache_ctrl_pkg::*;
();

    // controller to datapath
    way_sel_e way_sel;
    // 0 selects CPU write data, 1 selects the memory line
    logic data_source_sel;
    // 1 puts the request tag on mem_adr instead of the victim tag
    logic tag_bypass_sel;
    logic load;
    logic load_lru;

    // datapath to controller
    logic hit_0;
    logic hit_1;
    // dirty bit of the way named by lru
    logic dirty;
    way_sel_e lru;

    modport ctrl (
        output way_sel, data_source_sel, tag_bypass_sel, load, load_lru,
        input  hit_0, hit_1, dirty, lru
    );

    modport dp (
        input  way_sel, data_source_sel, tag_bypass_sel, load, load_lru,
        output hit_0, hit_1, dirty, lru
    );

endinterface : cache_ctrl_if

// File: src/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // controller states
    // WRITEBACK only entered when the victim is dirty
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL
    } cache_state_e;

    // way selection, also the encoding of the per-set LRU bit
    typedef enum logic {
        WAY_0 = 1'b0,
        WAY_1 = 1'b1
    } way_sel_e;

endpackage : cache_ctrl_pkg

// File: src/lc3b_types_pkg.sv
`include "lc3b_cache_macros.svh"

package lc3b_types_pkg;

    // one full line as moved on both buses
    typedef logic [`CACHE_LINE_BITS-1:0] lc3b_cache_word;

    // byte-enable mask, bit i covers byte i of the line
    typedef logic [`CACHE_SEL_BITS-1:0] lc3b_cache_sel;

    // line address as seen on the Wishbone buses
    // tag in the upper bits, set index in the lower bits
    typedef logic [`CACHE_ADR_BITS-1:0] lc3b_line_addr;

    // stored per entry and compared on lookup
    typedef logic [`CACHE_TAG_BITS-1:0] lc3b_cache_tag;

    // selects one of the sets
    typedef logic [`CACHE_INDEX_BITS-1:0] lc3b_cache_index;

endpackage : lc3b_types_pkg

// File: src/lc3b_cache_macros.svh
`ifndef LC3B_CACHE_MACROS_SVH
`define LC3B_CACHE_MACROS_SVH

// geometry of the L1 data cache
// two ways, eight sets, one 128-bit line per entry

// width of a full cache line in bits
`define CACHE_LINE_BITS 128

// one byte select per byte of the line
`define CACHE_SEL_BITS 16

// a line address drops the byte offset of the CPU address
`define CACHE_ADR_BITS 12

// upper part of the line address
`define CACHE_TAG_BITS 9

// lower part of the line address, picks the set
`define CACHE_INDEX_BITS 3

// number of sets per way
`define CACHE_SETS 8

`endif
